//--- dv/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

	localparam int	MEM_WORDS	= 256;
	localparam int	IDX_LEN		= $clog2(MEM_WORDS);
	localparam int	WAIT_LIMIT	= 50;
	// completion tags for the order checks
	localparam int	TAG_DWR		= 0;
	localparam int	TAG_DRD		= 1;
	localparam int	TAG_IRD		= 2;

	// one table row, expected response filled in from the shadow memory
	typedef struct packed {
		logic				inst;
		logic				wr;
		logic	[31:0]		addr;
		logic	[31:0]		data;
		logic	[3:0]		strb;
		mem_bus_pkg::r_t	exp;
	} txn_t;

	logic				clk;
	logic				rst_i;
	mem_bus_pkg::ar_t	inst_ar;
	logic				inst_ar_valid;
	logic				inst_ar_ready;
	mem_bus_pkg::r_t	inst_r;
	logic				inst_r_valid;
	logic				inst_r_ready;
	mem_bus_pkg::ar_t	data_ar;
	logic				data_ar_valid;
	logic				data_ar_ready;
	mem_bus_pkg::r_t	data_r;
	logic				data_r_valid;
	logic				data_r_ready;
	mem_bus_pkg::aw_t	data_aw;
	logic				data_aw_valid;
	logic				data_aw_ready;
	mem_bus_pkg::w_t	data_w;
	logic				data_w_valid;
	logic				data_w_ready;
	mem_bus_pkg::b_t	data_b;
	logic				data_b_valid;
	logic				data_b_ready;

	logic	[31:0]	shadow	[MEM_WORDS];
	txn_t			txns	[$];
	int				done_order	[$];
	int				errors;
	int				timeouts;
	integer			seed;

	mem_subsys_top #(
		.MEM_WORDS ( MEM_WORDS )
	) i_dut (
		.clk             ( clk           ),
		.rst_i           ( rst_i         ),
		.inst_ar_i       ( inst_ar       ),
		.inst_ar_valid_i ( inst_ar_valid ),
		.inst_ar_ready_o ( inst_ar_ready ),
		.inst_r_o        ( inst_r        ),
		.inst_r_valid_o  ( inst_r_valid  ),
		.inst_r_ready_i  ( inst_r_ready  ),
		.data_ar_i       ( data_ar       ),
		.data_ar_valid_i ( data_ar_valid ),
		.data_ar_ready_o ( data_ar_ready ),
		.data_r_o        ( data_r        ),
		.data_r_valid_o  ( data_r_valid  ),
		.data_r_ready_i  ( data_r_ready  ),
		.data_aw_i       ( data_aw       ),
		.data_aw_valid_i ( data_aw_valid ),
		.data_aw_ready_o ( data_aw_ready ),
		.data_w_i        ( data_w        ),
		.data_w_valid_i  ( data_w_valid  ),
		.data_w_ready_o  ( data_w_ready  ),
		.data_b_o        ( data_b        ),
		.data_b_valid_o  ( data_b_valid  ),
		.data_b_ready_i  ( data_b_ready  )
	);

	always #5 clk = ~clk;

	task automatic check_r(input string name, input mem_bus_pkg::r_t got,
			input mem_bus_pkg::r_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got data %h resp %h, expected data %h resp %h",
				name, got.data, got.resp, exp.data, exp.resp);
		end
	endtask

	task automatic check_b(input string name, input mem_bus_pkg::b_t got,
			input mem_bus_pkg::b_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got resp %h, expected resp %h", name, got.resp, exp.resp);
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_order(input int want[$]);
		if (done_order.size() != want.size()) begin
			errors++;
			$display("CHECK FAILED completion count: got %h expected %h",
				done_order.size(), want.size());
		end else begin
			foreach (want[i]) begin
				if (done_order[i] != want[i]) begin
					errors++;
					$display("CHECK FAILED completion slot %0d: got %h expected %h",
						i, done_order[i], want[i]);
				end
			end
		end
	endtask

	// word index must fall inside the array
	function automatic logic in_range(input logic [31:0] addr);
		return addr[31:2] < 30'(MEM_WORDS);
	endfunction

	// shadow update with byte lanes, gives the expected b response
	function automatic mem_cfg_pkg::resp_e model_write(input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		if (!in_range(addr)) begin
			// dropped write
			return mem_cfg_pkg::RESP_SLVERR;
		end
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				shadow[addr[IDX_LEN + 1:2]][b * 8 +: 8] = data[b * 8 +: 8];
			end
		end
		return mem_cfg_pkg::RESP_OKAY;
	endfunction

	function automatic mem_bus_pkg::r_t model_read(input logic [31:0] addr);
		mem_bus_pkg::r_t r;
		// slverr reads come back as zero
		r.data = '0;
		r.resp = mem_cfg_pkg::RESP_SLVERR;
		if (in_range(addr)) begin
			r.data = shadow[addr[IDX_LEN + 1:2]];
			r.resp = mem_cfg_pkg::RESP_OKAY;
		end
		return r;
	endfunction

	task automatic add_txn(input logic inst, input logic wr, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		txn_t t;
		t.inst = inst;
		t.wr   = wr;
		t.addr = addr;
		t.data = data;
		t.strb = strb;
		if (wr) begin
			t.exp.data = '0;
			t.exp.resp = model_write(addr, data, strb);
		end else begin
			t.exp = model_read(addr);
		end
		txns.push_back(t);
	endtask

	// port selects, 1 means the fetch port
	function automatic logic ar_ready_of(input logic inst);
		return inst ? inst_ar_ready : data_ar_ready;
	endfunction

	function automatic logic r_valid_of(input logic inst);
		return inst ? inst_r_valid : data_r_valid;
	endfunction

	function automatic mem_bus_pkg::r_t r_of(input logic inst);
		return inst ? inst_r : data_r;
	endfunction

	task automatic read_txn(input logic inst, input logic [31:0] addr,
			input mem_bus_pkg::r_t exp, input int hold);
		mem_bus_pkg::r_t held;
		string pname;
		int waited;
		pname = inst ? "inst" : "data";
		@(posedge clk);
		if (inst) begin
			inst_ar       <= '{addr: addr};
			inst_ar_valid <= 1'b1;
			inst_r_ready  <= (hold == 0);
		end else begin
			data_ar       <= '{addr: addr};
			data_ar_valid <= 1'b1;
			data_r_ready  <= (hold == 0);
		end
		// may sit behind a higher priority grant
		waited = 0;
		@(negedge clk);
		while (!ar_ready_of(inst) && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!ar_ready_of(inst)) begin
			timeouts++;
			$display("timeout: %s read of %h was never accepted", pname, addr);
			return;
		end
		@(posedge clk);
		if (inst) begin
			inst_ar_valid <= 1'b0;
		end else begin
			data_ar_valid <= 1'b0;
		end
		waited = 0;
		@(negedge clk);
		while (!r_valid_of(inst) && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!r_valid_of(inst)) begin
			timeouts++;
			$display("timeout: %s read of %h got no read data", pname, addr);
			return;
		end
		done_order.push_back(inst ? TAG_IRD : TAG_DRD);
		check_r({pname, "_r"}, r_of(inst), exp);
		held = r_of(inst);
		// response frozen and the other port kept out
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			check_ready({pname, "_r_valid"}, r_valid_of(inst), 1'b1);
			check_r({pname, "_r held"}, r_of(inst), held);
			check_ready(inst ? "data_ar_ready" : "inst_ar_ready", ar_ready_of(!inst), 1'b0);
		end
		if (hold > 0) begin
			@(posedge clk);
			if (inst) begin
				inst_r_ready <= 1'b1;
			end else begin
				data_r_ready <= 1'b1;
			end
		end
	endtask

	task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input mem_bus_pkg::b_t exp);
		int waited;
		@(posedge clk);
		data_aw       <= '{addr: addr};
		data_w        <= '{data: data, strb: strb};
		data_aw_valid <= 1'b1;
		data_w_valid  <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!data_aw_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!data_aw_ready) begin
			timeouts++;
			$display("timeout: data write to %h was never accepted", addr);
			return;
		end
		// aw and w are taken together
		check_ready("data_w_ready", data_w_ready, 1'b1);
		@(posedge clk);
		data_aw_valid <= 1'b0;
		data_w_valid  <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!data_b_valid && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!data_b_valid) begin
			timeouts++;
			$display("timeout: data write to %h got no write response", addr);
			return;
		end
		done_order.push_back(TAG_DWR);
		check_b("data_b", data_b, exp);
	endtask

	initial begin
		mem_bus_pkg::r_t		exp_d;
		mem_bus_pkg::r_t		exp_i;
		mem_cfg_pkg::resp_e		exp_w;
		int						want	[$];
		int						hold;
		clk           = 1'b0;
		rst_i         = 1'b1;
		inst_ar       = '0;
		inst_ar_valid = 1'b0;
		inst_r_ready  = 1'b1;
		data_ar       = '0;
		data_ar_valid = 1'b0;
		data_r_ready  = 1'b1;
		data_aw       = '0;
		data_aw_valid = 1'b0;
		data_w        = '0;
		data_w_valid  = 1'b0;
		data_b_ready  = 1'b1;
		errors        = 0;
		timeouts      = 0;
		seed          = 32'hbea8_40c0;

		// full words, then partial strobes on top
		add_txn(1'b0, 1'b1, 32'h0000_0010, 32'hdead_beef, 4'hf);
		add_txn(1'b0, 1'b0, 32'h0000_0010, 32'h0, 4'h0);
		add_txn(1'b0, 1'b1, 32'h0000_0010, 32'h1122_3344, 4'h5);
		add_txn(1'b0, 1'b0, 32'h0000_0010, 32'h0, 4'h0);
		add_txn(1'b0, 1'b1, 32'h0000_0024, 32'hcafe_f00d, 4'hf);
		add_txn(1'b0, 1'b1, 32'h0000_0024, 32'hab00_0000, 4'h8);
		add_txn(1'b0, 1'b0, 32'h0000_0024, 32'h0, 4'h0);
		// fetch port sees the shared array
		add_txn(1'b1, 1'b0, 32'h0000_0010, 32'h0, 4'h0);
		add_txn(1'b1, 1'b0, 32'h0000_0024, 32'h0, 4'h0);
		// word 273 aliases word 17 in the low index bits
		add_txn(1'b0, 1'b1, 32'h0000_0044, 32'h5a5a_0001, 4'hf);
		add_txn(1'b0, 1'b1, 32'h0000_0444, 32'hffff_ffff, 4'hf);
		add_txn(1'b0, 1'b0, 32'h0000_0444, 32'h0, 4'h0);
		add_txn(1'b1, 1'b0, 32'h0000_0444, 32'h0, 4'h0);
		add_txn(1'b0, 1'b0, 32'h8000_0010, 32'h0, 4'h0);
		add_txn(1'b0, 1'b0, 32'h0000_0044, 32'h0, 4'h0);
		// last word in range
		add_txn(1'b0, 1'b1, 32'h0000_03fc, 32'h8765_4321, 4'hf);
		add_txn(1'b1, 1'b0, 32'h0000_03fc, 32'h0, 4'h0);
		// word 256 is the first one out, aliases word 0
		add_txn(1'b0, 1'b1, 32'h0000_0000, 32'h0123_4567, 4'hf);
		add_txn(1'b0, 1'b1, 32'h0000_0400, 32'h89ab_cdef, 4'hf);
		add_txn(1'b0, 1'b0, 32'h0000_0400, 32'h0, 4'h0);
		add_txn(1'b0, 1'b0, 32'h0000_0000, 32'h0, 4'h0);

		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		check_ready("inst_ar_ready", inst_ar_ready, 1'b0);
		check_ready("inst_r_valid", inst_r_valid, 1'b0);
		check_ready("data_ar_ready", data_ar_ready, 1'b0);
		check_ready("data_r_valid", data_r_valid, 1'b0);
		check_ready("data_aw_ready", data_aw_ready, 1'b0);
		check_ready("data_w_ready", data_w_ready, 1'b0);
		check_ready("data_b_valid", data_b_valid, 1'b0);

		foreach (txns[i]) begin
			if (txns[i].wr) begin
				write_txn(txns[i].addr, txns[i].data, txns[i].strb, '{resp: txns[i].exp.resp});
			end else begin
				read_txn(txns[i].inst, txns[i].addr, txns[i].exp, 0);
			end
		end

		// all three at once, fixed priority decides
		exp_w = model_write(32'h0000_0080, 32'h0bad_f00d, 4'hf);
		exp_d = model_read(32'h0000_0080);
		exp_i = model_read(32'h0000_0080);
		done_order.delete();
		fork
			write_txn(32'h0000_0080, 32'h0bad_f00d, 4'hf, '{resp: exp_w});
			read_txn(1'b0, 32'h0000_0080, exp_d, 0);
			read_txn(1'b1, 32'h0000_0080, exp_i, 0);
		join
		want.delete();
		want.push_back(TAG_DWR);
		want.push_back(TAG_DRD);
		want.push_back(TAG_IRD);
		check_order(want);

		// data read stalled on r ready, fetch waits behind it
		hold  = 1 + int'($unsigned($random(seed)) % 8);
		$display("data r ready held low for %0d cycles", hold);
		exp_d = model_read(32'h0000_0010);
		exp_i = model_read(32'h0000_0024);
		done_order.delete();
		fork
			read_txn(1'b0, 32'h0000_0010, exp_d, hold);
			read_txn(1'b1, 32'h0000_0024, exp_i, 0);
		join
		want.delete();
		want.push_back(TAG_DRD);
		want.push_back(TAG_IRD);
		check_order(want);

		repeat (2) @(posedge clk);
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- files.f
source/mem_cfg_pkg.sv
source/mem_bus_pkg.sv
source/sram_array.sv
source/sram_ctrl.sv
source/axi_arbiter.sv
source/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module tb_mem_subsys -o tb_mem_subsys
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# result is decided by the log
if grep -qx "Everything OK" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- source/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
	input							clk				,
	input							rst_i			,
	// instruction fetch master, read only
	input	mem_bus_pkg::ar_t		inst_ar_i		,
	input							inst_ar_valid_i	,
	output	logic					inst_ar_ready_o	,
	output	mem_bus_pkg::r_t		inst_r_o		,
	output	logic					inst_r_valid_o	,
	input							inst_r_ready_i	,
	// load/store master
	input	mem_bus_pkg::ar_t		data_ar_i		,
	input							data_ar_valid_i	,
	output	logic					data_ar_ready_o	,
	output	mem_bus_pkg::r_t		data_r_o		,
	output	logic					data_r_valid_o	,
	input							data_r_ready_i	,
	input	mem_bus_pkg::aw_t		data_aw_i		,
	input							data_aw_valid_i	,
	output	logic					data_aw_ready_o	,
	input	mem_bus_pkg::w_t		data_w_i		,
	input							data_w_valid_i	,
	output	logic					data_w_ready_o	,
	output	mem_bus_pkg::b_t		data_b_o		,
	output	logic					data_b_valid_o	,
	input							data_b_ready_i	,
	// shared slave
	output	mem_bus_pkg::ar_t		slv_ar_o		,
	output	logic					slv_ar_valid_o	,
	input							slv_ar_ready_i	,
	input	mem_bus_pkg::r_t		slv_r_i			,
	input							slv_r_valid_i	,
	output	logic					slv_r_ready_o	,
	output	mem_bus_pkg::aw_t		slv_aw_o		,
	output	logic					slv_aw_valid_o	,
	input							slv_aw_ready_i	,
	output	mem_bus_pkg::w_t		slv_w_o			,
	output	logic					slv_w_valid_o	,
	input							slv_w_ready_i	,
	input	mem_bus_pkg::b_t		slv_b_i			,
	input							slv_b_valid_i	,
	output	logic					slv_b_ready_o
);

	mem_cfg_pkg::grant_e	grant_q;
	mem_cfg_pkg::grant_e	grant_d;

	// grant update
	always_comb begin
		grant_d = grant_q;
		case (grant_q)
			mem_cfg_pkg::GNT_NONE: begin
				// fixed priority, write needs aw and w together
				if (data_aw_valid_i && data_w_valid_i) begin
					grant_d = mem_cfg_pkg::GNT_DWR;
				end else if (data_ar_valid_i) begin
					grant_d = mem_cfg_pkg::GNT_DRD;
				end else if (inst_ar_valid_i) begin
					grant_d = mem_cfg_pkg::GNT_IRD;
				end
			end
			mem_cfg_pkg::GNT_DWR: begin
				// free on b handshake
				if (slv_b_valid_i && slv_b_ready_o) begin
					grant_d = mem_cfg_pkg::GNT_NONE;
				end
			end
			default: begin
				// both read owners free on r handshake
				if (slv_r_valid_i && slv_r_ready_o) begin
					grant_d = mem_cfg_pkg::GNT_NONE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			grant_q <= mem_cfg_pkg::GNT_NONE;
		end else begin
			grant_q <= grant_d;
		end
	end

	// channel routing
	always_comb begin
		// payloads go everywhere, only the valids qualify them
		slv_ar_o = (grant_q == mem_cfg_pkg::GNT_IRD) ? inst_ar_i : data_ar_i;
		slv_aw_o = data_aw_i;
		slv_w_o  = data_w_i;
		inst_r_o = slv_r_i;
		data_r_o = slv_r_i;
		data_b_o = slv_b_i;
		// losers see everything low
		slv_ar_valid_o  = 1'b0;
		slv_r_ready_o   = 1'b0;
		slv_aw_valid_o  = 1'b0;
		slv_w_valid_o   = 1'b0;
		slv_b_ready_o   = 1'b0;
		inst_ar_ready_o = 1'b0;
		inst_r_valid_o  = 1'b0;
		data_ar_ready_o = 1'b0;
		data_r_valid_o  = 1'b0;
		data_aw_ready_o = 1'b0;
		data_w_ready_o  = 1'b0;
		data_b_valid_o  = 1'b0;
		case (grant_q)
			mem_cfg_pkg::GNT_DWR: begin
				slv_aw_valid_o  = data_aw_valid_i;
				slv_w_valid_o   = data_w_valid_i;
				data_aw_ready_o = slv_aw_ready_i;
				data_w_ready_o  = slv_w_ready_i;
				data_b_valid_o  = slv_b_valid_i;
				slv_b_ready_o   = data_b_ready_i;
			end
			mem_cfg_pkg::GNT_DRD: begin
				slv_ar_valid_o  = data_ar_valid_i;
				data_ar_ready_o = slv_ar_ready_i;
				data_r_valid_o  = slv_r_valid_i;
				slv_r_ready_o   = data_r_ready_i;
			end
			mem_cfg_pkg::GNT_IRD: begin
				slv_ar_valid_o  = inst_ar_valid_i;
				inst_ar_ready_o = slv_ar_ready_i;
				inst_r_valid_o  = slv_r_valid_i;
				slv_r_ready_o   = inst_r_ready_i;
			end
			default: begin
				// idle, nothing routed
			end
		endcase
	end

endmodule

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

	// read address channel
	typedef struct packed {
		logic [mem_cfg_pkg::ADDR_LEN - 1:0] addr;
	} ar_t;

	// read data channel
	typedef struct packed {
		logic [mem_cfg_pkg::DATA_LEN - 1:0] data;
		// slverr comes back with zero data
		mem_cfg_pkg::resp_e resp;
	} r_t;

	// write address channel
	typedef struct packed {
		logic [mem_cfg_pkg::ADDR_LEN - 1:0] addr;
	} aw_t;

	// write data channel
	typedef struct packed {
		logic [mem_cfg_pkg::DATA_LEN - 1:0] data;
		// bit n enables byte lane n
		logic [mem_cfg_pkg::STRB_LEN - 1:0] strb;
	} w_t;

	// write response channel
	typedef struct packed {
		mem_cfg_pkg::resp_e resp;
	} b_t;

endpackage

//--- source/mem_cfg_pkg.sv
package mem_cfg_pkg;

	// bus widths shared by both masters and the sram
	localparam int ADDR_LEN = 32;
	localparam int DATA_LEN = 32;
	// one strobe bit per byte lane
	localparam int STRB_LEN = DATA_LEN / 8;

	// response code on r and b
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		// address beyond the array
		RESP_SLVERR = 2'b10
	} resp_e;

	// current owner of the shared slave
	typedef enum logic [1:0] {
		GNT_NONE = 2'd0,
		GNT_DWR  = 2'd1,
		GNT_DRD  = 2'd2,
		GNT_IRD  = 2'd3
	} grant_e;

endpackage

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
	parameter int	MEM_WORDS	= 1024
) (
	input							clk				,
	input							rst_i			,
	// instruction fetch master
	input	mem_bus_pkg::ar_t		inst_ar_i		,
	input							inst_ar_valid_i	,
	output	logic					inst_ar_ready_o	,
	output	mem_bus_pkg::r_t		inst_r_o		,
	output	logic					inst_r_valid_o	,
	input							inst_r_ready_i	,
	// load/store master
	input	mem_bus_pkg::ar_t		data_ar_i		,
	input							data_ar_valid_i	,
	output	logic					data_ar_ready_o	,
	output	mem_bus_pkg::r_t		data_r_o		,
	output	logic					data_r_valid_o	,
	input							data_r_ready_i	,
	input	mem_bus_pkg::aw_t		data_aw_i		,
	input							data_aw_valid_i	,
	output	logic					data_aw_ready_o	,
	input	mem_bus_pkg::w_t		data_w_i		,
	input							data_w_valid_i	,
	output	logic					data_w_ready_o	,
	output	mem_bus_pkg::b_t		data_b_o		,
	output	logic					data_b_valid_o	,
	input							data_b_ready_i
);

	localparam int	IDX_LEN	= $clog2(MEM_WORDS);

	// arbiter to controller
	mem_bus_pkg::ar_t	slv_ar;
	logic				slv_ar_valid;
	logic				slv_ar_ready;
	mem_bus_pkg::r_t	slv_r;
	logic				slv_r_valid;
	logic				slv_r_ready;
	mem_bus_pkg::aw_t	slv_aw;
	logic				slv_aw_valid;
	logic				slv_aw_ready;
	mem_bus_pkg::w_t	slv_w;
	logic				slv_w_valid;
	logic				slv_w_ready;
	mem_bus_pkg::b_t	slv_b;
	logic				slv_b_valid;
	logic				slv_b_ready;

	// controller to array
	logic									mem_ren;
	logic	[IDX_LEN - 1:0]					mem_raddr;
	logic	[mem_cfg_pkg::DATA_LEN - 1:0]	mem_rdata;
	logic									mem_wen;
	logic	[IDX_LEN - 1:0]					mem_waddr;
	logic	[mem_cfg_pkg::DATA_LEN - 1:0]	mem_wdata;
	logic	[mem_cfg_pkg::STRB_LEN - 1:0]	mem_wstrb;

	// master ports match by name
	axi_arbiter u_arbiter (
		.*,
		.slv_ar_o       ( slv_ar       ),
		.slv_ar_valid_o ( slv_ar_valid ),
		.slv_ar_ready_i ( slv_ar_ready ),
		.slv_r_i        ( slv_r        ),
		.slv_r_valid_i  ( slv_r_valid  ),
		.slv_r_ready_o  ( slv_r_ready  ),
		.slv_aw_o       ( slv_aw       ),
		.slv_aw_valid_o ( slv_aw_valid ),
		.slv_aw_ready_i ( slv_aw_ready ),
		.slv_w_o        ( slv_w        ),
		.slv_w_valid_o  ( slv_w_valid  ),
		.slv_w_ready_i  ( slv_w_ready  ),
		.slv_b_i        ( slv_b        ),
		.slv_b_valid_i  ( slv_b_valid  ),
		.slv_b_ready_o  ( slv_b_ready  )
	);

	sram_ctrl #(
		.MEM_WORDS   ( MEM_WORDS )
	) u_sram_ctrl (
		.clk         ( clk          ),
		.rst_i       ( rst_i        ),
		.ar_i        ( slv_ar       ),
		.ar_valid_i  ( slv_ar_valid ),
		.ar_ready_o  ( slv_ar_ready ),
		.r_o         ( slv_r        ),
		.r_valid_o   ( slv_r_valid  ),
		.r_ready_i   ( slv_r_ready  ),
		.aw_i        ( slv_aw       ),
		.aw_valid_i  ( slv_aw_valid ),
		.aw_ready_o  ( slv_aw_ready ),
		.w_i         ( slv_w        ),
		.w_valid_i   ( slv_w_valid  ),
		.w_ready_o   ( slv_w_ready  ),
		.b_o         ( slv_b        ),
		.b_valid_o   ( slv_b_valid  ),
		.b_ready_i   ( slv_b_ready  ),
		.mem_ren_o   ( mem_ren      ),
		.mem_raddr_o ( mem_raddr    ),
		.mem_rdata_i ( mem_rdata    ),
		.mem_wen_o   ( mem_wen      ),
		.mem_waddr_o ( mem_waddr    ),
		.mem_wdata_o ( mem_wdata    ),
		.mem_wstrb_o ( mem_wstrb    )
	);

	sram_array #(
		.MEM_WORDS ( MEM_WORDS )
	) u_sram_array (
		.clk     ( clk       ),
		.ren_i   ( mem_ren   ),
		.raddr_i ( mem_raddr ),
		.rdata_o ( mem_rdata ),
		.wen_i   ( mem_wen   ),
		.waddr_i ( mem_waddr ),
		.wdata_i ( mem_wdata ),
		.wstrb_i ( mem_wstrb )
	);

endmodule

//--- source/sram_array.sv
`timescale 1ns/1ps

module sram_array #(
	parameter int	MEM_WORDS	= 1024,
	localparam int	IDX_LEN		= $clog2(MEM_WORDS)
) (
	input											clk		,
	// read port, data one cycle after ren
	input											ren_i	,
	input			[IDX_LEN - 1:0]					raddr_i	,
	output	logic	[mem_cfg_pkg::DATA_LEN - 1:0]	rdata_o	,
	// write port, per byte lane
	input											wen_i	,
	input			[IDX_LEN - 1:0]					waddr_i	,
	input			[mem_cfg_pkg::DATA_LEN - 1:0]	wdata_i	,
	input			[mem_cfg_pkg::STRB_LEN - 1:0]	wstrb_i
);

	logic	[mem_cfg_pkg::DATA_LEN - 1:0]	mem	[MEM_WORDS];

	// byte lanes with strobe set
	always_ff @(posedge clk) begin
		if (wen_i) begin
			for (int b = 0; b < mem_cfg_pkg::STRB_LEN; b++) begin
				if (wstrb_i[b]) begin
					mem[waddr_i][b * 8 +: 8] <= wdata_i[b * 8 +: 8];
				end
			end
		end
	end

	// registered read, holds until next ren
	always_ff @(posedge clk) begin
		if (ren_i) begin
			rdata_o <= mem[raddr_i];
		end
	end

endmodule

//--- source/sram_ctrl.sv
`timescale 1ns/1ps

module sram_ctrl #(
	parameter int	MEM_WORDS	= 1024,
	localparam int	IDX_LEN		= $clog2(MEM_WORDS)
) (
	input													clk			,
	input													rst_i		,
	// axi-lite slave
	input	mem_bus_pkg::ar_t								ar_i		,
	input													ar_valid_i	,
	output	logic											ar_ready_o	,
	output	mem_bus_pkg::r_t								r_o			,
	output	logic											r_valid_o	,
	input													r_ready_i	,
	input	mem_bus_pkg::aw_t								aw_i		,
	input													aw_valid_i	,
	output	logic											aw_ready_o	,
	input	mem_bus_pkg::w_t								w_i			,
	input													w_valid_i	,
	output	logic											w_ready_o	,
	output	mem_bus_pkg::b_t								b_o			,
	output	logic											b_valid_o	,
	input													b_ready_i	,
	// array port
	output	logic											mem_ren_o	,
	output	logic	[IDX_LEN - 1:0]							mem_raddr_o	,
	input			[mem_cfg_pkg::DATA_LEN - 1:0]			mem_rdata_i	,
	output	logic											mem_wen_o	,
	output	logic	[IDX_LEN - 1:0]							mem_waddr_o	,
	output	logic	[mem_cfg_pkg::DATA_LEN - 1:0]			mem_wdata_o	,
	output	logic	[mem_cfg_pkg::STRB_LEN - 1:0]			mem_wstrb_o
);

	// byte offset bits dropped for the word index
	localparam int	OFF_LEN		= $clog2(mem_cfg_pkg::STRB_LEN);
	localparam int	WORD_LEN	= mem_cfg_pkg::ADDR_LEN - OFF_LEN;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD_ISSUE,
		ST_RD_RESP,
		ST_WR_RESP
	} state_e;

	state_e									state_q;
	logic									err_q;
	logic									wen_q;
	logic	[IDX_LEN - 1:0]					raddr_q;
	logic	[IDX_LEN - 1:0]					waddr_q;
	logic	[mem_cfg_pkg::DATA_LEN - 1:0]	wdata_q;
	logic	[mem_cfg_pkg::STRB_LEN - 1:0]	wstrb_q;
	logic	[WORD_LEN - 1:0]				ar_word;
	logic	[WORD_LEN - 1:0]				aw_word;
	logic									ar_in_range;
	logic									aw_in_range;
	logic									wr_take;
	logic									rd_take;

	// byte address to word index, range check on the full index
	assign ar_word     = ar_i.addr[mem_cfg_pkg::ADDR_LEN - 1:OFF_LEN];
	assign aw_word     = aw_i.addr[mem_cfg_pkg::ADDR_LEN - 1:OFF_LEN];
	assign ar_in_range = ar_word < WORD_LEN'(MEM_WORDS);
	assign aw_in_range = aw_word < WORD_LEN'(MEM_WORDS);

	// write wins if both show up in idle
	assign wr_take    = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
	assign rd_take    = (state_q == ST_IDLE) && ar_valid_i && !(aw_valid_i && w_valid_i);
	assign aw_ready_o = wr_take;
	assign w_ready_o  = wr_take;
	assign ar_ready_o = rd_take;

	// out of range never reaches the array
	assign mem_ren_o   = (state_q == ST_RD_ISSUE) && !err_q;
	assign mem_raddr_o = raddr_q;
	assign mem_wen_o   = wen_q;
	assign mem_waddr_o = waddr_q;
	assign mem_wdata_o = wdata_q;
	assign mem_wstrb_o = wstrb_q;

	// responses, stable while held in the resp states
	assign r_valid_o = state_q == ST_RD_RESP;
	assign r_o.data  = err_q ? '0 : mem_rdata_i;
	assign r_o.resp  = err_q ? mem_cfg_pkg::RESP_SLVERR : mem_cfg_pkg::RESP_OKAY;
	assign b_valid_o = state_q == ST_WR_RESP;
	assign b_o.resp  = err_q ? mem_cfg_pkg::RESP_SLVERR : mem_cfg_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			wen_q   <= 1'b0;
		end else begin
			// write strobe is a single pulse
			wen_q <= wr_take && aw_in_range;
			case (state_q)
				ST_IDLE: begin
					if (wr_take) begin
						state_q <= ST_WR_RESP;
					end else if (rd_take) begin
						state_q <= ST_RD_ISSUE;
					end
				end
				// array read in flight
				ST_RD_ISSUE: state_q <= ST_RD_RESP;
				ST_RD_RESP: begin
					if (r_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
				ST_WR_RESP: begin
					if (b_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request capture
	always_ff @(posedge clk) begin
		if (rd_take) begin
			raddr_q <= ar_word[IDX_LEN - 1:0];
			err_q   <= !ar_in_range;
		end
		if (wr_take) begin
			waddr_q <= aw_word[IDX_LEN - 1:0];
			wdata_q <= w_i.data;
			wstrb_q <= w_i.strb;
			err_q   <= !aw_in_range;
		end
	end

endmodule
